// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = fm_core_tb
FILELIST = fm_core.f

BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: fm_core.f
hdl/fm_pkg.sv
hdl/fm_bus_sync.sv
hdl/fm_mmr.sv
hdl/fm_timers.sv
hdl/fm_phase_gen.sv
hdl/fm_core.sv
sim/fm_core_tb.sv

// File: hdl/fm_bus_sync.sv
`timescale 1ns/1ps
`default_nettype none

module fm_bus_sync (
	input  logic             clk_int,
	input  logic             rst_n,
	input  fm_pkg::bus_data_t din,
	input  logic [1:0]       addr,
	input  logic             cs_n,
	input  logic             wr_n,
	input  logic             busy,
	input  logic             flag_a,
	input  logic             flag_b,
	output fm_pkg::bus_data_t din_s,
	output logic             addr_wr,
	output logic             data_wr,
	output fm_pkg::bus_data_t dout
);

	fm_pkg::bus_data_t din_r;
	logic [1:0] addr_r;
	logic cs_r;
	logic wr_r;
	logic wr_prev;
	logic wr_now;
	logic wr_start;

	// Write is active while both strobes are low
	assign wr_now = ~cs_r & ~wr_r;
	assign wr_start = wr_now & ~wr_prev;

	always_ff @(posedge clk_int) begin
		if (!rst_n) begin
			cs_r <= 1'b1;
			wr_r <= 1'b1;
			wr_prev <= 1'b0;
			addr_wr <= 1'b0;
			data_wr <= 1'b0;
			dout <= '0;
		end else begin
			cs_r <= cs_n;
			wr_r <= wr_n;
			wr_prev <= wr_now;
			// Odd addresses carry data, even ones the register number
			addr_wr <= wr_start & ~addr_r[0];
			data_wr <= wr_start & addr_r[0];
			dout <= {busy, 5'b00000, flag_b, flag_a};
		end
	end

	// Byte is held for the strobe cycle
	always_ff @(posedge clk_int) begin
		din_r <= din;
		addr_r <= addr;
		if (wr_start)
			din_s <= din_r;
	end

	a_one_strobe: assert property (@(posedge clk_int) disable iff (!rst_n)
		!(addr_wr && data_wr));

endmodule

`default_nettype wire

// File: hdl/fm_core.sv
`timescale 1ns/1ps
`default_nettype none

module fm_core #(
	parameter int SAMPLE_DIV = 24,
	parameter int BUSY_CYCLES = 32
) (
	input  logic              clk_int,
	input  logic              rst_n,
	input  fm_pkg::bus_data_t din,
	input  logic [1:0]        addr,
	input  logic              cs_n,
	input  logic              wr_n,
	output fm_pkg::bus_data_t dout,
	output logic              irq_n,
	output fm_pkg::snd_t      snd,
	output logic              sample
);

	fm_pkg::bus_data_t din_s;
	logic addr_wr;
	logic data_wr;
	logic busy;
	// Timer controls
	fm_pkg::timer_a_t value_a;
	fm_pkg::timer_b_t value_b;
	logic load_a;
	logic load_b;
	logic run_a;
	logic run_b;
	logic irq_en_a;
	logic irq_en_b;
	logic clr_flag_a;
	logic clr_flag_b;
	logic flag_a;
	logic flag_b;
	// Channel pitch
	fm_pkg::fnum_t fnum;
	fm_pkg::block_t block;

	fm_bus_sync bus_sync_i (
		.clk_int (clk_int),
		.rst_n   (rst_n),
		.din     (din),
		.addr    (addr),
		.cs_n    (cs_n),
		.wr_n    (wr_n),
		.busy    (busy),
		.flag_a  (flag_a),
		.flag_b  (flag_b),
		.din_s   (din_s),
		.addr_wr (addr_wr),
		.data_wr (data_wr),
		.dout    (dout)
	);

	fm_mmr #(
		.BUSY_CYCLES (BUSY_CYCLES)
	) mmr_i (
		.clk_int    (clk_int),
		.rst_n      (rst_n),
		.din_s      (din_s),
		.addr_wr    (addr_wr),
		.data_wr    (data_wr),
		.busy       (busy),
		.value_a    (value_a),
		.value_b    (value_b),
		.load_a     (load_a),
		.load_b     (load_b),
		.run_a      (run_a),
		.run_b      (run_b),
		.irq_en_a   (irq_en_a),
		.irq_en_b   (irq_en_b),
		.clr_flag_a (clr_flag_a),
		.clr_flag_b (clr_flag_b),
		.fnum       (fnum),
		.block      (block)
	);

	fm_timers timers_i (
		.clk_int    (clk_int),
		.rst_n      (rst_n),
		.sample     (sample),
		.value_a    (value_a),
		.value_b    (value_b),
		.load_a     (load_a),
		.load_b     (load_b),
		.run_a      (run_a),
		.run_b      (run_b),
		.irq_en_a   (irq_en_a),
		.irq_en_b   (irq_en_b),
		.clr_flag_a (clr_flag_a),
		.clr_flag_b (clr_flag_b),
		.flag_a     (flag_a),
		.flag_b     (flag_b),
		.irq_n      (irq_n)
	);

	fm_phase_gen #(
		.SAMPLE_DIV (SAMPLE_DIV)
	) phase_gen_i (
		.clk_int (clk_int),
		.rst_n   (rst_n),
		.fnum    (fnum),
		.block   (block),
		.sample  (sample),
		.snd     (snd)
	);

endmodule

`default_nettype wire

// File: hdl/fm_mmr.sv
`timescale 1ns/1ps
`default_nettype none

module fm_mmr #(
	parameter int BUSY_CYCLES = 32
) (
	input  logic              clk_int,
	input  logic              rst_n,
	input  fm_pkg::bus_data_t din_s,
	input  logic              addr_wr,
	input  logic              data_wr,
	output logic              busy,
	output fm_pkg::timer_a_t  value_a,
	output fm_pkg::timer_b_t  value_b,
	output logic              load_a,
	output logic              load_b,
	output logic              run_a,
	output logic              run_b,
	output logic              irq_en_a,
	output logic              irq_en_b,
	output logic              clr_flag_a,
	output logic              clr_flag_b,
	output fm_pkg::fnum_t     fnum,
	output fm_pkg::block_t    block
);

	localparam int BUSY_W = $clog2(BUSY_CYCLES + 1);

	fm_pkg::reg_addr_t reg_sel;
	logic [BUSY_W-1:0] busy_cnt;
	logic wr_en;

	// Writes during the busy period are lost
	assign wr_en = data_wr & ~busy;
	assign busy = (busy_cnt != '0);

	always_ff @(posedge clk_int) begin
		if (!rst_n) begin
			reg_sel <= '0;
			busy_cnt <= '0;
		end else begin
			if (addr_wr)
				reg_sel <= din_s;
			if (wr_en)
				busy_cnt <= BUSY_W'(BUSY_CYCLES);
			else if (busy)
				busy_cnt <= busy_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk_int) begin
		if (!rst_n) begin
			value_a <= '0;
			value_b <= '0;
			run_a <= 1'b0;
			run_b <= 1'b0;
			irq_en_a <= 1'b0;
			irq_en_b <= 1'b0;
			load_a <= 1'b0;
			load_b <= 1'b0;
			clr_flag_a <= 1'b0;
			clr_flag_b <= 1'b0;
			fnum <= '0;
			block <= '0;
		end else begin
			// Pulses last one cycle
			load_a <= 1'b0;
			load_b <= 1'b0;
			clr_flag_a <= 1'b0;
			clr_flag_b <= 1'b0;
			if (wr_en) begin
				case (reg_sel)
					fm_pkg::REG_TIMER_A_HI: value_a[9:2] <= din_s;
					fm_pkg::REG_TIMER_A_LO: value_a[1:0] <= din_s[1:0];
					fm_pkg::REG_TIMER_B: value_b <= din_s;
					fm_pkg::REG_TIMER_CTRL: begin
						// Timer restarts only when run goes from 0 to 1
						load_a <= din_s[0] & ~run_a;
						load_b <= din_s[1] & ~run_b;
						run_a <= din_s[0];
						run_b <= din_s[1];
						irq_en_a <= din_s[2];
						irq_en_b <= din_s[3];
						clr_flag_a <= din_s[4];
						clr_flag_b <= din_s[5];
					end
					fm_pkg::REG_FNUM_LO: fnum[7:0] <= din_s;
					fm_pkg::REG_FNUM_HI: begin
						block <= din_s[5:3];
						fnum[10:8] <= din_s[2:0];
					end
					default: ;
				endcase
			end
		end
	end

	a_busy_drop: assert property (@(posedge clk_int) disable iff (!rst_n)
		(data_wr && busy) |=> $stable({value_a, value_b, run_a, run_b,
			irq_en_a, irq_en_b, fnum, block}));

endmodule

`default_nettype wire

// File: hdl/fm_phase_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fm_phase_gen #(
	parameter int SAMPLE_DIV = 24
) (
	input  logic           clk_int,
	input  logic           rst_n,
	input  fm_pkg::fnum_t  fnum,
	input  fm_pkg::block_t block,
	output logic           sample,
	output fm_pkg::snd_t   snd
);

	localparam int DIV_W = $clog2(SAMPLE_DIV);

	logic [DIV_W-1:0] div_cnt;
	logic div_end;
	fm_pkg::phase_t phase;
	fm_pkg::phase_t phase_inc;

	assign div_end = (div_cnt == DIV_W'(SAMPLE_DIV - 1));

	// Octave shift, then halved
	assign phase_inc = (fm_pkg::phase_t'(fnum) << block) >> 1;

	always_ff @(posedge clk_int) begin
		if (!rst_n) begin
			div_cnt <= '0;
			sample <= 1'b0;
		end else begin
			sample <= div_end;
			if (div_end)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	// Phase moves on the same edge that raises sample
	always_ff @(posedge clk_int) begin
		if (!rst_n)
			phase <= '0;
		else if (div_end)
			phase <= phase + phase_inc;
	end

	// Sawtooth from the top of the accumulator
	assign snd = fm_pkg::snd_t'(phase[19:6]);

	a_sample_pulse: assert property (@(posedge clk_int) disable iff (!rst_n)
		sample |=> !sample);

endmodule

`default_nettype wire

// File: hdl/fm_pkg.sv
`default_nettype none

package fm_pkg;

	// Host bus byte and latched register number
	typedef logic [7:0] bus_data_t;
	typedef logic [7:0] reg_addr_t;

	// Timer load values
	typedef logic [9:0] timer_a_t;
	typedef logic [7:0] timer_b_t;

	// Channel pitch
	typedef logic [10:0] fnum_t;
	typedef logic [2:0] block_t;

	// Phase accumulator and output sample
	typedef logic [19:0] phase_t;
	typedef logic signed [13:0] snd_t;

	// Register numbers, same numbering as the original chip
	localparam reg_addr_t REG_TIMER_A_HI = 8'h24;
	localparam reg_addr_t REG_TIMER_A_LO = 8'h25;
	localparam reg_addr_t REG_TIMER_B = 8'h26;
	localparam reg_addr_t REG_TIMER_CTRL = 8'h27;
	localparam reg_addr_t REG_FNUM_LO = 8'hA0;
	localparam reg_addr_t REG_FNUM_HI = 8'hA4;

endpackage

`default_nettype wire

// File: hdl/fm_timers.sv
`timescale 1ns/1ps
`default_nettype none

module fm_timers (
	input  logic             clk_int,
	input  logic             rst_n,
	input  logic             sample,
	input  fm_pkg::timer_a_t value_a,
	input  fm_pkg::timer_b_t value_b,
	input  logic             load_a,
	input  logic             load_b,
	input  logic             run_a,
	input  logic             run_b,
	input  logic             irq_en_a,
	input  logic             irq_en_b,
	input  logic             clr_flag_a,
	input  logic             clr_flag_b,
	output logic             flag_a,
	output logic             flag_b,
	output logic             irq_n
);

	fm_pkg::timer_a_t cnt_a;
	fm_pkg::timer_b_t cnt_b;
	logic [3:0] pre_b;
	logic tick_a;
	logic tick_b;
	logic ovf_a;
	logic ovf_b;

	assign tick_a = sample & run_a;
	// Timer B steps once every 16 sample ticks
	assign tick_b = sample & run_b & (pre_b == 4'hF);
	assign ovf_a = tick_a & (cnt_a == '1);
	assign ovf_b = tick_b & (cnt_b == '1);

	always_ff @(posedge clk_int) begin
		if (!rst_n) begin
			cnt_a <= '0;
			cnt_b <= '0;
			pre_b <= '0;
		end else begin
			if (load_a || ovf_a)
				cnt_a <= value_a;
			else if (tick_a)
				cnt_a <= cnt_a + 1'b1;

			if (load_b)
				pre_b <= '0;
			else if (sample && run_b)
				pre_b <= pre_b + 1'b1;

			if (load_b || ovf_b)
				cnt_b <= value_b;
			else if (tick_b)
				cnt_b <= cnt_b + 1'b1;
		end
	end

	// Sticky flags, a new overflow wins over a clear
	always_ff @(posedge clk_int) begin
		if (!rst_n) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			if (ovf_a)
				flag_a <= 1'b1;
			else if (clr_flag_a)
				flag_a <= 1'b0;
			if (ovf_b)
				flag_b <= 1'b1;
			else if (clr_flag_b)
				flag_b <= 1'b0;
		end
	end

	assign irq_n = ~((flag_a & irq_en_a) | (flag_b & irq_en_b));

	a_flag_on_tick: assert property (@(posedge clk_int) disable iff (!rst_n)
		($rose(flag_a) || $rose(flag_b)) |-> $past(sample));

endmodule

`default_nettype wire

// File: sim/fm_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fm_core_tb;

	localparam int SAMPLE_DIV = 24;
	localparam int BUSY_CYCLES = 32;
	localparam int CLK_PERIOD = 40;
	localparam logic [7:0] REG_TIMER_A_HI = 8'h24;
	localparam logic [7:0] REG_TIMER_A_LO = 8'h25;
	localparam logic [7:0] REG_TIMER_B = 8'h26;
	localparam logic [7:0] REG_TIMER_CTRL = 8'h27;
	localparam logic [7:0] REG_FNUM_LO = 8'hA0;
	localparam logic [7:0] REG_FNUM_HI = 8'hA4;
	localparam int PHASE_SETS = 4;
	localparam int PHASE_TICKS = 16;
	// Longest timer A, clear and timer B runs, phase runs, and all bus writes
	localparam int RUN_TICKS = 256 + 256 + 256 + PHASE_SETS * (PHASE_TICKS + 6) + 64;
	localparam int WATCHDOG_NS = RUN_TICKS * SAMPLE_DIV * CLK_PERIOD + 20000;

	logic clk_int;
	logic rst_n;
	logic [7:0] din;
	logic [1:0] addr;
	logic cs_n;
	logic wr_n;
	logic [7:0] dout;
	logic irq_n;
	logic signed [13:0] snd;
	logic sample;

	int err_count = 0;
	int test_count = 0;
	int fail_count = 0;
	int tick_count = 0;
	int since_tick = 0;
	int phase_checks = 0;
	logic [16:0] lfsr = 17'd65866;
	// Reference channel state
	logic [19:0] mdl_phase = '0;
	logic [10:0] mdl_fnum = '0;
	logic [2:0] mdl_block = '0;
	logic signed [13:0] mdl_snd = '0;

	fm_core #(
		.SAMPLE_DIV  (SAMPLE_DIV),
		.BUSY_CYCLES (BUSY_CYCLES)
	) dut_i (
		.clk_int (clk_int),
		.rst_n   (rst_n),
		.din     (din),
		.addr    (addr),
		.cs_n    (cs_n),
		.wr_n    (wr_n),
		.dout    (dout),
		.irq_n   (irq_n),
		.snd     (snd),
		.sample  (sample)
	);

	initial begin
		clk_int = 1'b0;
		forever #(CLK_PERIOD / 2) clk_int = ~clk_int;
	end

	// Fibonacci LFSR, x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic rand_bits(input int n, output logic [15:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	// Phase advance is fnum raised by block, halved, wrapping at 20 bits
	function automatic logic [19:0] phase_step(input logic [19:0] ph, input logic [10:0] f,
		input logic [2:0] b);
		logic [19:0] inc;
		inc = ({9'b0, f} << b) >> 1;
		return ph + inc;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
		err_count++;
	endtask

	task automatic report_error(input string what);
		$display("Error at %0t ns: %s", $time, what);
		err_count++;
	endtask

	task automatic close_test(input string name, input int errs_before);
		test_count++;
		if (err_count != errs_before) begin
			fail_count++;
			$display("Test %s: failed with %0d errors", name, err_count - errs_before);
		end else begin
			$display("Test %s: ok", name);
		end
	endtask

	// Counts every sample pulse on the edge that ends it
	// Pulses must come exactly SAMPLE_DIV clocks apart
	always @(posedge clk_int) begin
		if (!rst_n) begin
			tick_count <= 0;
			since_tick <= 0;
		end else if (sample) begin
			if (tick_count > 0 && since_tick != SAMPLE_DIV)
				report_mismatch("sample period", since_tick, SAMPLE_DIV);
			tick_count <= tick_count + 1;
			since_tick <= 1;
		end else begin
			since_tick <= since_tick + 1;
		end
	end

	// Reference phase steps on each pulse, snd must hold in between
	always @(negedge clk_int) begin
		if (rst_n) begin
			if (sample) begin
				mdl_phase = phase_step(mdl_phase, mdl_fnum, mdl_block);
				mdl_snd = mdl_phase[19:6];
				phase_checks++;
			end
			if (snd !== mdl_snd)
				report_mismatch("snd", {18'b0, snd}, {18'b0, mdl_snd});
		end
	end

	task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
		@(negedge clk_int);
		addr = a;
		din = d;
		cs_n = 1'b0;
		wr_n = 1'b0;
		repeat (2) @(negedge clk_int);
		cs_n = 1'b1;
		wr_n = 1'b1;
	endtask

	task automatic read_status(output logic [7:0] st);
		@(negedge clk_int);
		cs_n = 1'b0;
		wr_n = 1'b1;
		@(negedge clk_int);
		st = dout;
		cs_n = 1'b1;
	endtask

	// Poll status bit 7, counting clocks from the first clock of the data write
	task automatic wait_ready();
		int n;
		cs_n = 1'b0;
		wr_n = 1'b1;
		repeat (2) @(negedge clk_int);
		n = 4;
		if (dout[7] !== 1'b1)
			report_error("status bit 7 was not set right after a data write");
		while (dout[7] !== 1'b0 && n < BUSY_CYCLES + 4) begin
			@(negedge clk_int);
			n++;
		end
		if (dout[7] !== 1'b0)
			report_error($sformatf("busy still set %0d clocks after a data write", n));
		cs_n = 1'b1;
	endtask

	task automatic write_reg(input logic [7:0] r, input logic [7:0] v, output int at_tick);
		bus_write(2'd0, r);
		bus_write(2'd1, v);
		at_tick = tick_count;
		wait_ready();
	endtask

	// Data write starts right after a pulse so the new pitch is in place before the next
	task automatic write_pitch(input logic [7:0] r, input logic [7:0] v);
		bus_write(2'd0, r);
		@(negedge clk_int);
		while (!sample)
			@(negedge clk_int);
		bus_write(2'd1, v);
		if (r == REG_FNUM_HI) begin
			mdl_block = v[5:3];
			mdl_fnum[10:8] = v[2:0];
		end else begin
			mdl_fnum[7:0] = v;
		end
		wait_ready();
	endtask

	initial begin
		int t0;
		int ovf_tick;
		int ticks;
		int expect_ticks;
		int errs_before;
		int n;
		int k;
		logic irq_low;
		logic [15:0] r;
		logic [9:0] value_a;
		logic [7:0] value_b;
		logic [7:0] st;
		din = '0;
		addr = '0;
		cs_n = 1'b1;
		wr_n = 1'b1;
		rst_n = 1'b0;
		repeat (2) @(posedge clk_int);
		@(negedge clk_int);
		rst_n = 1'b1;

		errs_before = err_count;
		read_status(st);
		if (irq_n !== 1'b1)
			report_mismatch("irq_n", irq_n, 1);
		if (st !== 8'h00)
			report_mismatch("dout", st, 0);
		if (snd !== 14'sd0)
			report_mismatch("snd", {18'b0, snd}, 0);
		close_test("reset", errs_before);

		// Second byte to the timer A high register arrives while busy
		errs_before = err_count;
		rand_bits(7, r);
		value_a = {3'b110, r[6:0]};
		bus_write(2'd0, REG_TIMER_A_HI);
		bus_write(2'd1, value_a[9:2]);
		bus_write(2'd1, ~value_a[9:2]);
		wait_ready();
		write_reg(REG_TIMER_A_LO, {6'b0, value_a[1:0]}, t0);
		close_test("busy", errs_before);

		errs_before = err_count;
		write_reg(REG_TIMER_CTRL, 8'h05, t0);
		expect_ticks = 1024 - int'(value_a);
		n = 0;
		while (irq_n !== 1'b0 && n < (expect_ticks + 2) * SAMPLE_DIV) begin
			@(negedge clk_int);
			n++;
		end
		ticks = tick_count - t0;
		ovf_tick = tick_count;
		if (irq_n !== 1'b0)
			report_error("irq_n never fell for timer A");
		else if (ticks < expect_ticks - 1 || ticks > expect_ticks + 1)
			report_mismatch("timer A ticks", ticks, expect_ticks);
		read_status(st);
		if (st[0] !== 1'b1)
			report_mismatch("dout[0]", st[0], 1);
		close_test("timer_a", errs_before);

		errs_before = err_count;
		write_reg(REG_TIMER_CTRL, 8'h15, t0);
		if (irq_n !== 1'b1)
			report_mismatch("irq_n", irq_n, 1);
		read_status(st);
		if (st[0] !== 1'b0)
			report_mismatch("dout[0]", st[0], 0);
		n = 0;
		while (irq_n !== 1'b0 && n < (expect_ticks + 2) * SAMPLE_DIV) begin
			@(negedge clk_int);
			n++;
		end
		ticks = tick_count - ovf_tick;
		if (irq_n !== 1'b0)
			report_error("flag A did not set again after the clear");
		else if (ticks != expect_ticks)
			report_mismatch("timer A period", ticks, expect_ticks);
		close_test("clear_a", errs_before);

		// Timer B alone, interrupt enable off
		errs_before = err_count;
		rand_bits(4, r);
		value_b = {4'hF, r[3:0]};
		write_reg(REG_TIMER_B, value_b, t0);
		write_reg(REG_TIMER_CTRL, 8'h02, t0);
		expect_ticks = 16 * (256 - int'(value_b));
		irq_low = 1'b0;
		cs_n = 1'b0;
		n = 0;
		while (dout[1] !== 1'b1 && n < (expect_ticks + 2) * SAMPLE_DIV) begin
			@(negedge clk_int);
			n++;
			if (irq_n !== 1'b1)
				irq_low = 1'b1;
		end
		cs_n = 1'b1;
		ticks = tick_count - t0;
		if (dout[1] !== 1'b1)
			report_error("flag B never set");
		else if (ticks < expect_ticks - 1 || ticks > expect_ticks + 1)
			report_mismatch("timer B ticks", ticks, expect_ticks);
		if (irq_low)
			report_error("irq_n fell while irq enable B was off");
		close_test("timer_b", errs_before);

		errs_before = err_count;
		for (k = 0; k < PHASE_SETS; k++) begin
			rand_bits(14, r);
			write_pitch(REG_FNUM_HI, {2'b00, r[13:11], r[10:8]});
			write_pitch(REG_FNUM_LO, r[7:0]);
			repeat (PHASE_TICKS) @(posedge sample);
		end
		close_test("phase", errs_before);

		$display("Summary: %0d tests, %0d failed, %0d errors, %0d sample checks",
			test_count, fail_count, err_count, phase_checks);
		if (err_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
